/* src/rocache_bus_pkg.sv */
`default_nettype none

package rocache_bus_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------

  // Both ports carry word addresses, not byte addresses
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // ----------------------------------------
  // Port payloads
  // ----------------------------------------

  // Processor side read request
  typedef struct packed {
    addr_t addr;
  } cpu_req_t;

  // Memory side read request, one word per transfer
  typedef struct packed {
    addr_t addr;
  } mem_req_t;

endpackage

`default_nettype wire

/* src/rocache_cfg_pkg.sv */
`default_nettype none

package rocache_cfg_pkg;

  import rocache_bus_pkg::*;

  // Single cacheable window, end_addr is exclusive
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } region_t;

  typedef enum logic {
    RouteCache  = 1'b0,
    RouteBypass = 1'b1
  } route_e;

  // ----------------------------------------
  // Cache line helpers
  // ----------------------------------------

  // Tag bits left over after the line index and the word offset
  function automatic int unsigned tag_width(input int unsigned line_count,
                                            input int unsigned line_words);
    return AddrWidth - $clog2(line_count) - $clog2(line_words);
  endfunction

  function automatic logic in_region(input region_t region, input addr_t addr);
    return (addr >= region.start_addr) && (addr < region.end_addr);
  endfunction

endpackage

`default_nettype wire

/* src/rocache_router.sv */
`timescale 1ns/100ps
`default_nettype none

module rocache_router
  import rocache_bus_pkg::*;
  import rocache_cfg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     enable_i,
  input  region_t  region_i,
  input  logic     busy_i,
  // Processor port
  input  cpu_req_t cpu_req_i,
  input  logic     cpu_req_valid_i,
  output logic     cpu_req_ready_o,
  output data_t    cpu_rsp_data_o,
  output logic     cpu_rsp_valid_o,
  input  logic     cpu_rsp_ready_i,
  // Lookup side
  output logic     lookup_valid_o,
  output addr_t    lookup_addr_o,
  input  logic     lookup_hit_i,
  input  data_t    lookup_data_i,
  input  logic     lookup_done_i,
  // Fill side
  output logic     fill_valid_o,
  output addr_t    fill_addr_o,
  input  logic     fill_done_i,
  input  data_t    fill_data_i,
  // Bypass side
  output logic     byp_req_valid_o,
  input  logic     byp_req_ready_i,
  output addr_t    byp_addr_o,
  input  logic     byp_rsp_valid_i,
  input  data_t    byp_rsp_data_i
);

  typedef enum logic [2:0] {
    StIdle,
    StLookup,
    StFill,
    StBypReq,
    StBypRsp,
    StRespond
  } state_e;

  state_e state_q, state_d;
  route_e route;
  logic   accept;
  logic   rsp_load;
  data_t  rsp_data_d;
  data_t  rsp_data_q;
  addr_t  addr_q;

  // Bypass is the default route
  assign route = (enable_i && in_region(region_i, cpu_req_i.addr)) ? RouteCache : RouteBypass;

  assign cpu_req_ready_o = (state_q == StIdle) && !busy_i;
  assign accept          = cpu_req_valid_i && cpu_req_ready_o;

  // Lookup starts in the accept cycle so a hit answers two cycles later
  assign lookup_valid_o = accept && (route == RouteCache);
  assign lookup_addr_o  = cpu_req_i.addr;

  assign fill_valid_o = (state_q == StLookup) && lookup_done_i && !lookup_hit_i;
  assign fill_addr_o  = addr_q;

  assign byp_req_valid_o = (state_q == StBypReq);
  assign byp_addr_o      = addr_q;

  assign cpu_rsp_valid_o = (state_q == StRespond);
  assign cpu_rsp_data_o  = rsp_data_q;

  always_comb begin
    state_d    = state_q;
    rsp_load   = 1'b0;
    rsp_data_d = lookup_data_i;
    unique case (state_q)
      StIdle: begin
        if (accept) begin
          state_d = (route == RouteCache) ? StLookup : StBypReq;
        end
      end
      StLookup: begin
        if (lookup_done_i) begin
          if (lookup_hit_i) begin
            state_d  = StRespond;
            rsp_load = 1'b1;
          end else begin
            state_d = StFill;
          end
        end
      end
      StFill: begin
        if (fill_done_i) begin
          state_d    = StRespond;
          rsp_load   = 1'b1;
          rsp_data_d = fill_data_i;
        end
      end
      StBypReq: begin
        if (byp_req_ready_i) begin
          state_d = StBypRsp;
        end
      end
      StBypRsp: begin
        if (byp_rsp_valid_i) begin
          state_d    = StRespond;
          rsp_load   = 1'b1;
          rsp_data_d = byp_rsp_data_i;
        end
      end
      StRespond: begin
        // Response held until the processor takes it
        if (cpu_rsp_ready_i) begin
          state_d = StIdle;
        end
      end
      default: begin
        state_d = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= cpu_req_i.addr;
    end
    if (rsp_load) begin
      rsp_data_q <= rsp_data_d;
    end
  end

endmodule

`default_nettype wire

/* src/rocache_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

module rocache_lookup
  import rocache_bus_pkg::*;
  import rocache_cfg_pkg::*;
#(
  parameter int unsigned LineCount = 16,
  parameter int unsigned LineWords = 4,
  localparam int unsigned OffWidth = $clog2(LineWords),
  localparam int unsigned IdxWidth = $clog2(LineCount),
  localparam int unsigned TagWidth = tag_width(LineCount, LineWords)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_valid_i,
  output logic                  flush_ready_o,
  output logic                  busy_o,
  // Lookup port
  input  logic                  lookup_valid_i,
  input  addr_t                 lookup_addr_i,
  output logic                  lookup_hit_o,
  output data_t                 lookup_data_o,
  output logic                  lookup_done_o,
  // Line write port
  input  logic                  line_write_i,
  input  logic [IdxWidth-1:0]   line_index_i,
  input  logic [TagWidth-1:0]   line_tag_i,
  input  data_t [LineWords-1:0] line_data_i
);

  logic [LineCount-1:0]  valid_q;
  logic [TagWidth-1:0]   tag_q  [LineCount];
  data_t [LineWords-1:0] data_q [LineCount];

  logic [OffWidth-1:0] rd_off;
  logic [IdxWidth-1:0] rd_idx;
  logic [TagWidth-1:0] rd_tag;

  logic                flush_busy_q;
  logic [IdxWidth-1:0] flush_idx_q;
  logic                flush_start;
  logic                flush_last;

  // Word address split: tag | index | offset
  assign rd_off = lookup_addr_i[OffWidth-1:0];
  assign rd_idx = lookup_addr_i[OffWidth +: IdxWidth];
  assign rd_tag = lookup_addr_i[AddrWidth-1 -: TagWidth];

  // ----------------------------------------
  // Flush walk
  // ----------------------------------------

  // A lookup in the same cycle wins, the flush waits one cycle
  assign flush_start   = flush_valid_i && !flush_busy_q && !lookup_valid_i;
  assign flush_last    = flush_busy_q && (&flush_idx_q);
  assign flush_ready_o = flush_last;
  assign busy_o        = flush_busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_busy_q <= 1'b0;
      flush_idx_q  <= '0;
    end else if (flush_start) begin
      flush_busy_q <= 1'b1;
      flush_idx_q  <= '0;
    end else if (flush_busy_q) begin
      flush_busy_q <= !flush_last;
      flush_idx_q  <= flush_idx_q + 1'b1;
    end
  end

  // ----------------------------------------
  // Arrays
  // ----------------------------------------

  // One valid bit cleared per flush cycle, a line write sets its bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      if (flush_busy_q) begin
        valid_q[flush_idx_q] <= 1'b0;
      end
      if (line_write_i) begin
        valid_q[line_index_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (line_write_i) begin
      tag_q[line_index_i]  <= line_tag_i;
      data_q[line_index_i] <= line_data_i;
    end
  end

  // ----------------------------------------
  // Read and tag compare
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lookup_done_o <= 1'b0;
      lookup_hit_o  <= 1'b0;
    end else begin
      lookup_done_o <= lookup_valid_i;
      lookup_hit_o  <= lookup_valid_i && valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    end
  end

  // Addressed word of the line
  always_ff @(posedge clk_i) begin
    if (lookup_valid_i) begin
      lookup_data_o <= data_q[rd_idx][rd_off];
    end
  end

endmodule

`default_nettype wire

/* src/rocache_refill.sv */
`timescale 1ns/100ps
`default_nettype none

module rocache_refill
  import rocache_bus_pkg::*;
  import rocache_cfg_pkg::*;
#(
  parameter int unsigned LineCount = 16,
  parameter int unsigned LineWords = 4,
  localparam int unsigned OffWidth = $clog2(LineWords),
  localparam int unsigned IdxWidth = $clog2(LineCount),
  localparam int unsigned TagWidth = tag_width(LineCount, LineWords)
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Fill request from the router
  input  logic                  fill_valid_i,
  input  addr_t                 fill_addr_i,
  output logic                  fill_done_o,
  output data_t                 fill_data_o,
  // Memory side
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  output addr_t                 req_addr_o,
  input  logic                  rsp_valid_i,
  input  data_t                 rsp_data_i,
  // Line write into the arrays
  output logic                  line_write_o,
  output logic [IdxWidth-1:0]   line_index_o,
  output logic [TagWidth-1:0]   line_tag_o,
  output data_t [LineWords-1:0] line_data_o
);

  typedef enum logic [1:0] {
    FillIdle,
    FillReq,
    FillWait,
    FillDone
  } state_e;

  state_e                state_q, state_d;
  addr_t                 addr_q;
  logic [OffWidth-1:0]   cnt_q;
  logic                  cnt_last;
  data_t [LineWords-1:0] buf_q;

  assign cnt_last = &cnt_q;

  // Words are read in order from the line-aligned address
  assign req_valid_o = (state_q == FillReq);
  assign req_addr_o  = {addr_q[AddrWidth-1:OffWidth], cnt_q};

  assign line_write_o = (state_q == FillDone);
  assign line_index_o = addr_q[OffWidth +: IdxWidth];
  assign line_tag_o   = addr_q[AddrWidth-1 -: TagWidth];
  assign line_data_o  = buf_q;

  // Requested word goes back together with the line write
  assign fill_done_o = (state_q == FillDone);
  assign fill_data_o = buf_q[addr_q[OffWidth-1:0]];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FillIdle: begin
        if (fill_valid_i) begin
          state_d = FillReq;
        end
      end
      FillReq: begin
        if (req_ready_i) begin
          state_d = FillWait;
        end
      end
      FillWait: begin
        if (rsp_valid_i) begin
          state_d = cnt_last ? FillDone : FillReq;
        end
      end
      FillDone: begin
        state_d = FillIdle;
      end
      default: begin
        state_d = FillIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FillIdle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if ((state_q == FillIdle) && fill_valid_i) begin
        cnt_q <= '0;
      end else if ((state_q == FillWait) && rsp_valid_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Line buffer
  always_ff @(posedge clk_i) begin
    if ((state_q == FillIdle) && fill_valid_i) begin
      addr_q <= fill_addr_i;
    end
    if ((state_q == FillWait) && rsp_valid_i) begin
      buf_q[cnt_q] <= rsp_data_i;
    end
  end

endmodule

`default_nettype wire

/* src/rocache_mem_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module rocache_mem_mux
  import rocache_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // Bypass client
  input  logic     byp_req_valid_i,
  output logic     byp_req_ready_o,
  input  addr_t    byp_addr_i,
  output logic     byp_rsp_valid_o,
  output data_t    byp_rsp_data_o,
  // Refill client
  input  logic     fill_req_valid_i,
  output logic     fill_req_ready_o,
  input  addr_t    fill_addr_i,
  output logic     fill_rsp_valid_o,
  output data_t    fill_rsp_data_o,
  // Memory port
  output mem_req_t mem_req_o,
  output logic     mem_req_valid_o,
  input  logic     mem_req_ready_i,
  input  data_t    mem_rsp_data_i,
  input  logic     mem_rsp_valid_i
);

  logic pending_q;
  logic owner_fill_q;
  logic mem_fire;

  // Refill has priority, nothing new goes out while a response is due
  assign mem_req_valid_o  = !pending_q && (fill_req_valid_i || byp_req_valid_i);
  assign mem_req_o.addr   = fill_req_valid_i ? fill_addr_i : byp_addr_i;
  assign fill_req_ready_o = !pending_q && mem_req_ready_i;
  assign byp_req_ready_o  = !pending_q && mem_req_ready_i && !fill_req_valid_i;
  assign mem_fire         = mem_req_valid_o && mem_req_ready_i;

  // Response steering
  assign fill_rsp_valid_o = mem_rsp_valid_i && owner_fill_q;
  assign byp_rsp_valid_o  = mem_rsp_valid_i && !owner_fill_q;
  assign fill_rsp_data_o  = mem_rsp_data_i;
  assign byp_rsp_data_o   = mem_rsp_data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q    <= 1'b0;
      owner_fill_q <= 1'b0;
    end else if (mem_fire) begin
      pending_q    <= 1'b1;
      owner_fill_q <= fill_req_valid_i;
    end else if (mem_rsp_valid_i) begin
      pending_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* src/rocache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rocache_top
  import rocache_bus_pkg::*;
  import rocache_cfg_pkg::*;
#(
  parameter int unsigned LineCount = 16,
  parameter int unsigned LineWords = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     enable_i,
  input  region_t  region_i,
  input  logic     flush_valid_i,
  output logic     flush_ready_o,
  // Processor port
  input  cpu_req_t cpu_req_i,
  input  logic     cpu_req_valid_i,
  output logic     cpu_req_ready_o,
  output data_t    cpu_rsp_data_o,
  output logic     cpu_rsp_valid_o,
  input  logic     cpu_rsp_ready_i,
  // Memory port
  output mem_req_t mem_req_o,
  output logic     mem_req_valid_o,
  input  logic     mem_req_ready_i,
  input  data_t    mem_rsp_data_i,
  input  logic     mem_rsp_valid_i
);

  localparam int unsigned IdxWidth = $clog2(LineCount);
  localparam int unsigned TagWidth = tag_width(LineCount, LineWords);

  logic busy;

  // Router to lookup
  logic  lookup_valid;
  addr_t lookup_addr;
  logic  lookup_hit;
  data_t lookup_data;
  logic  lookup_done;

  // Router to refill
  logic  fill_valid;
  addr_t fill_addr;
  logic  fill_done;
  data_t fill_data;

  // Clients of the memory mux
  logic  byp_req_valid;
  logic  byp_req_ready;
  addr_t byp_addr;
  logic  byp_rsp_valid;
  data_t byp_rsp_data;
  logic  refill_req_valid;
  logic  refill_req_ready;
  addr_t refill_req_addr;
  logic  refill_rsp_valid;
  data_t refill_rsp_data;

  // Line write port
  logic                  line_write;
  logic [IdxWidth-1:0]   line_index;
  logic [TagWidth-1:0]   line_tag;
  data_t [LineWords-1:0] line_data;

  rocache_router i_router (
    .clk_i,
    .rst_ni,
    .enable_i,
    .region_i,
    .busy_i          ( busy           ),
    .cpu_req_i,
    .cpu_req_valid_i,
    .cpu_req_ready_o,
    .cpu_rsp_data_o,
    .cpu_rsp_valid_o,
    .cpu_rsp_ready_i,
    .lookup_valid_o  ( lookup_valid   ),
    .lookup_addr_o   ( lookup_addr    ),
    .lookup_hit_i    ( lookup_hit     ),
    .lookup_data_i   ( lookup_data    ),
    .lookup_done_i   ( lookup_done    ),
    .fill_valid_o    ( fill_valid     ),
    .fill_addr_o     ( fill_addr      ),
    .fill_done_i     ( fill_done      ),
    .fill_data_i     ( fill_data      ),
    .byp_req_valid_o ( byp_req_valid  ),
    .byp_req_ready_i ( byp_req_ready  ),
    .byp_addr_o      ( byp_addr       ),
    .byp_rsp_valid_i ( byp_rsp_valid  ),
    .byp_rsp_data_i  ( byp_rsp_data   )
  );

  rocache_lookup #(
    .LineCount ( LineCount ),
    .LineWords ( LineWords )
  ) i_lookup (
    .clk_i,
    .rst_ni,
    .flush_valid_i,
    .flush_ready_o,
    .busy_o         ( busy         ),
    .lookup_valid_i ( lookup_valid ),
    .lookup_addr_i  ( lookup_addr  ),
    .lookup_hit_o   ( lookup_hit   ),
    .lookup_data_o  ( lookup_data  ),
    .lookup_done_o  ( lookup_done  ),
    .line_write_i   ( line_write   ),
    .line_index_i   ( line_index   ),
    .line_tag_i     ( line_tag     ),
    .line_data_i    ( line_data    )
  );

  rocache_refill #(
    .LineCount ( LineCount ),
    .LineWords ( LineWords )
  ) i_refill (
    .clk_i,
    .rst_ni,
    .fill_valid_i ( fill_valid       ),
    .fill_addr_i  ( fill_addr        ),
    .fill_done_o  ( fill_done        ),
    .fill_data_o  ( fill_data        ),
    .req_valid_o  ( refill_req_valid ),
    .req_ready_i  ( refill_req_ready ),
    .req_addr_o   ( refill_req_addr  ),
    .rsp_valid_i  ( refill_rsp_valid ),
    .rsp_data_i   ( refill_rsp_data  ),
    .line_write_o ( line_write       ),
    .line_index_o ( line_index       ),
    .line_tag_o   ( line_tag         ),
    .line_data_o  ( line_data        )
  );

  rocache_mem_mux i_mem_mux (
    .clk_i,
    .rst_ni,
    .byp_req_valid_i  ( byp_req_valid    ),
    .byp_req_ready_o  ( byp_req_ready    ),
    .byp_addr_i       ( byp_addr         ),
    .byp_rsp_valid_o  ( byp_rsp_valid    ),
    .byp_rsp_data_o   ( byp_rsp_data     ),
    .fill_req_valid_i ( refill_req_valid ),
    .fill_req_ready_o ( refill_req_ready ),
    .fill_addr_i      ( refill_req_addr  ),
    .fill_rsp_valid_o ( refill_rsp_valid ),
    .fill_rsp_data_o  ( refill_rsp_data  ),
    .mem_req_o,
    .mem_req_valid_o,
    .mem_req_ready_i,
    .mem_rsp_data_i,
    .mem_rsp_valid_i
  );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
  parameter int unsigned Period      = 8,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Reset released on a clock edge after the hold time
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

/* bench/tb_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_checker
  import rocache_bus_pkg::*;
  import rocache_cfg_pkg::*;
#(
  parameter int unsigned LineCount = 16,
  parameter int unsigned LineWords = 4
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        enable_i,
  input  region_t     region_i,
  input  int unsigned epoch_i,
  input  int unsigned test_id_i,
  input  logic        test_end_i,
  input  logic        flush_ready_i,
  input  cpu_req_t    cpu_req_i,
  input  logic        cpu_req_valid_i,
  input  logic        cpu_req_ready_i,
  input  data_t       cpu_rsp_data_i,
  input  logic        cpu_rsp_valid_i,
  input  logic        cpu_rsp_ready_i,
  input  mem_req_t    mem_req_i,
  input  logic        mem_req_valid_i,
  input  logic        mem_req_ready_i,
  // Expected word comes back from the reference function
  output addr_t       exp_addr_o,
  output int unsigned exp_epoch_o,
  input  data_t       exp_word_i,
  output int unsigned tests_passed_o,
  output int unsigned tests_failed_o,
  output int unsigned reads_o
);

  localparam int unsigned OffWidth = $clog2(LineWords);
  localparam int unsigned IdxWidth = $clog2(LineCount);

  typedef enum int {KindBypass, KindMiss, KindHit} kind_e;

  // Model of the cache contents
  logic        valid_m [LineCount];
  addr_t       line_m  [LineCount];
  int unsigned epoch_m [LineCount];

  logic        busy_q = 1'b0;
  logic        rsp_seen_q;
  logic        reset_checked_q = 1'b0;
  kind_e       kind_q;
  int unsigned cycles_q;
  int unsigned test_errors = 0;
  int unsigned test_reads = 0;
  addr_t       mem_addrs[$];

  initial begin
    tests_passed_o = 0;
    tests_failed_o = 0;
    reads_o        = 0;
    exp_addr_o     = '0;
    exp_epoch_o    = 0;
    foreach (valid_m[i]) valid_m[i] = 1'b0;
  end

  function automatic string test_name(input int unsigned id);
    case (id)
      0: return "bypass";
      1: return "miss_fill";
      2: return "hit";
      3: return "enable_off";
      4: return "flush";
      5: return "back_pressure";
      default: return "unknown";
    endcase
  endfunction

  task automatic value_error(input data_t expected, input data_t actual);
    $display("** Error test %s: addr %h expected %h actual %h",
             test_name(test_id_i), exp_addr_o, expected, actual);
    test_errors++;
  endtask

  task automatic fault(input string msg);
    $display("Error in test %s: %s", test_name(test_id_i), msg);
    test_errors++;
  endtask

  // Hit, miss or bypass decision of the model for an accepted read
  task automatic start_read();
    addr_t       line_no;
    int unsigned idx;
    logic        cacheable;
    line_no   = cpu_req_i.addr >> OffWidth;
    idx       = 32'(line_no[IdxWidth-1:0]);
    cacheable = enable_i && (cpu_req_i.addr >= region_i.start_addr)
                && (cpu_req_i.addr < region_i.end_addr);
    exp_addr_o = cpu_req_i.addr;
    if (!cacheable) begin
      kind_q      = KindBypass;
      exp_epoch_o = epoch_i;
    end else if (valid_m[idx] && (line_m[idx] == line_no)) begin
      kind_q      = KindHit;
      exp_epoch_o = epoch_m[idx];
    end else begin
      kind_q       = KindMiss;
      valid_m[idx] = 1'b1;
      line_m[idx]  = line_no;
      epoch_m[idx] = epoch_i;
      exp_epoch_o  = epoch_i;
    end
    mem_addrs.delete();
    cycles_q   = 0;
    rsp_seen_q = 1'b0;
    busy_q     = 1'b1;
  endtask

  task automatic finish_read();
    addr_t base;
    base = exp_addr_o & ~addr_t'(LineWords - 1);
    reads_o++;
    test_reads++;
    if (cpu_rsp_data_i !== exp_word_i) begin
      value_error(exp_word_i, cpu_rsp_data_i);
    end
    case (kind_q)
      KindBypass: begin
        if (mem_addrs.size() != 1 || mem_addrs[0] != exp_addr_o) begin
          fault($sformatf("bypass read of %h made %0d memory requests or used a wrong address",
                          exp_addr_o, mem_addrs.size()));
        end
      end
      KindMiss: begin
        if (mem_addrs.size() != int'(LineWords)) begin
          fault($sformatf("refill of %h made %0d memory requests", exp_addr_o,
                          mem_addrs.size()));
        end else begin
          for (int i = 0; i < int'(LineWords); i++) begin
            if (mem_addrs[i] != base + addr_t'(i)) begin
              fault($sformatf("refill of %h read %h out of order", exp_addr_o, mem_addrs[i]));
            end
          end
        end
      end
      default: begin
        if (mem_addrs.size() != 0) begin
          fault($sformatf("hit on %h went to memory", exp_addr_o));
        end
      end
    endcase
    busy_q = 1'b0;
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (!reset_checked_q) begin
        reset_checked_q = 1'b1;
        if (cpu_rsp_valid_i || mem_req_valid_i || flush_ready_i) begin
          fault("a valid or flush_ready output is high right after reset");
        end
      end
      if (flush_ready_i) begin
        foreach (valid_m[i]) valid_m[i] = 1'b0;
      end
      if (busy_q) begin
        cycles_q++;
        if (cpu_req_ready_i) begin
          fault("request port ready while a read is in flight");
        end
        if (mem_req_valid_i && mem_req_ready_i) begin
          mem_addrs.push_back(mem_req_i.addr);
        end
        if (cpu_rsp_valid_i && !rsp_seen_q) begin
          rsp_seen_q = 1'b1;
          if (kind_q == KindHit && cycles_q != 2) begin
            fault($sformatf("hit answered %0d cycles after the request", cycles_q));
          end
        end
        if (cpu_rsp_valid_i && cpu_rsp_ready_i) begin
          finish_read();
        end
      end else begin
        if (mem_req_valid_i && mem_req_ready_i) begin
          fault("memory request with no read in flight");
        end
        if (cpu_rsp_valid_i) begin
          fault("response with no read in flight");
        end
      end
      if (cpu_req_valid_i && cpu_req_ready_i) begin
        start_read();
      end
      if (test_end_i) begin
        if (test_errors == 0) begin
          $display("test %s: ok, %0d reads", test_name(test_id_i), test_reads);
          tests_passed_o++;
        end else begin
          $display("test %s: %0d errors", test_name(test_id_i), test_errors);
          tests_failed_o++;
        end
        test_errors = 0;
        test_reads  = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_top
  import rocache_bus_pkg::*;
  import rocache_cfg_pkg::*;
();

  localparam int unsigned LineCount  = 16;
  localparam int unsigned LineWords  = 4;
  localparam int unsigned NumTests   = 6;
  localparam int unsigned TestBudget = 3000;
  localparam logic [31:0] Seed       = 32'hdff470e0;

  logic        clk;
  logic        rst_n;
  logic        enable = 1'b1;
  region_t     region = '{start_addr: 32'h100, end_addr: 32'h200};
  logic        flush_valid = 1'b0;
  logic        flush_ready;
  cpu_req_t    cpu_req = '0;
  logic        cpu_req_valid = 1'b0;
  logic        cpu_req_ready;
  data_t       cpu_rsp_data;
  logic        cpu_rsp_valid;
  logic        cpu_rsp_ready = 1'b1;
  mem_req_t    mem_req;
  logic        mem_req_valid;
  logic        mem_req_ready = 1'b1;
  data_t       mem_rsp_data = '0;
  logic        mem_rsp_valid = 1'b0;

  int unsigned epoch = 0;
  int unsigned test_id = 0;
  logic        test_end = 1'b0;
  logic        bp_mode = 1'b0;
  logic [31:0] lat_rnd = Seed;
  logic [31:0] bp_rnd = Seed ^ 32'h1234_5678;
  int unsigned req_count [addr_t];

  addr_t       exp_addr;
  int unsigned exp_epoch;
  data_t       exp_word;
  int unsigned tests_passed;
  int unsigned tests_failed;
  int unsigned reads;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reference memory contents that change as a whole with the epoch
  function automatic data_t mem_word(input addr_t addr, input int unsigned ep);
    return (addr * 32'h9e3779b1) ^ {ep[7:0], 24'h00a5c3};
  endfunction

  assign exp_word = mem_word(exp_addr, exp_epoch);

  tb_clock #(.Period(8), .ResetCycles(8)) u_clock (.clk_o(clk), .rst_no(rst_n));

  rocache_top #(.LineCount(LineCount), .LineWords(LineWords)) uut (
    .clk_i(clk), .rst_ni(rst_n), .enable_i(enable), .region_i(region),
    .flush_valid_i(flush_valid), .flush_ready_o(flush_ready),
    .cpu_req_i(cpu_req), .cpu_req_valid_i(cpu_req_valid), .cpu_req_ready_o(cpu_req_ready),
    .cpu_rsp_data_o(cpu_rsp_data), .cpu_rsp_valid_o(cpu_rsp_valid),
    .cpu_rsp_ready_i(cpu_rsp_ready),
    .mem_req_o(mem_req), .mem_req_valid_o(mem_req_valid), .mem_req_ready_i(mem_req_ready),
    .mem_rsp_data_i(mem_rsp_data), .mem_rsp_valid_i(mem_rsp_valid)
  );

  tb_checker #(.LineCount(LineCount), .LineWords(LineWords)) u_checker (
    .clk_i(clk), .rst_ni(rst_n), .enable_i(enable), .region_i(region),
    .epoch_i(epoch), .test_id_i(test_id), .test_end_i(test_end),
    .flush_ready_i(flush_ready),
    .cpu_req_i(cpu_req), .cpu_req_valid_i(cpu_req_valid), .cpu_req_ready_i(cpu_req_ready),
    .cpu_rsp_data_i(cpu_rsp_data), .cpu_rsp_valid_i(cpu_rsp_valid),
    .cpu_rsp_ready_i(cpu_rsp_ready),
    .mem_req_i(mem_req), .mem_req_valid_i(mem_req_valid), .mem_req_ready_i(mem_req_ready),
    .exp_addr_o(exp_addr), .exp_epoch_o(exp_epoch), .exp_word_i(exp_word),
    .tests_passed_o(tests_passed), .tests_failed_o(tests_failed), .reads_o(reads)
  );

  // ----------------------------------------
  // Memory model with one response per request
  // ----------------------------------------

  initial begin
    addr_t       a;
    int unsigned lat;
    forever begin
      @(posedge clk);
      mem_rsp_valid <= 1'b0;
      if (rst_n && mem_req_valid && mem_req_ready) begin
        a = mem_req.addr;
        req_count[a]++;
        lat_rnd = xorshift(lat_rnd);
        lat     = lat_rnd % 4;
        repeat (lat) @(posedge clk);
        mem_rsp_data  <= mem_word(a, epoch);
        mem_rsp_valid <= 1'b1;
      end
    end
  end

  // Random back-pressure on both ready inputs
  always @(posedge clk) begin
    bp_rnd        <= xorshift(bp_rnd);
    cpu_rsp_ready <= bp_mode ? bp_rnd[0] : 1'b1;
    mem_req_ready <= bp_rnd[1];
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  task automatic read_word(input addr_t addr);
    cpu_req       <= '{addr: addr};
    cpu_req_valid <= 1'b1;
    do @(posedge clk); while (!cpu_req_ready);
    cpu_req_valid <= 1'b0;
    do @(posedge clk); while (!(cpu_rsp_valid && cpu_rsp_ready));
  endtask

  task automatic flush_cache();
    flush_valid <= 1'b1;
    do @(posedge clk); while (!flush_ready);
    flush_valid <= 1'b0;
  endtask

  task automatic next_epoch();
    epoch <= epoch + 1;
    @(posedge clk);
  endtask

  task automatic end_test();
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
    @(posedge clk);
    test_id <= test_id + 1;
    @(posedge clk);
  endtask

  initial begin
    logic [31:0] addr_rnd;
    addr_rnd = xorshift(Seed);
    @(posedge rst_n);
    repeat (2) @(posedge clk);
    read_word(32'h1000);
    read_word(32'h0003);
    end_test();
    read_word(32'h104);
    read_word(32'h105);
    read_word(32'h123);
    end_test();
    next_epoch();
    read_word(32'h106);
    read_word(32'h104);
    read_word(32'h120);
    end_test();
    enable <= 1'b0;
    read_word(32'h104);
    read_word(32'h150);
    enable <= 1'b1;
    end_test();
    flush_cache();
    read_word(32'h104);
    read_word(32'h107);
    end_test();
    bp_mode <= 1'b1;
    for (int i = 0; i < 60; i++) begin
      addr_rnd = xorshift(addr_rnd);
      read_word(32'h0f0 + addr_rnd % 32'h120);
      if (i % 15 == 14) next_epoch();
    end
    bp_mode <= 1'b0;
    end_test();
    $display("%0d tests passed, %0d failed, %0d reads checked, %0d memory addresses used",
             tests_passed, tests_failed, reads, req_count.num());
    if (tests_failed == 0 && tests_passed == NumTests) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    repeat (NumTests * TestBudget) @(posedge clk);
    $display("Watchdog: the tests did not finish within %0d cycles", NumTests * TestBudget);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
src/rocache_bus_pkg.sv
src/rocache_cfg_pkg.sv
src/rocache_router.sv
src/rocache_lookup.sv
src/rocache_refill.sv
src/rocache_mem_mux.sv
src/rocache_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_top -f tb.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

# Pass only when the testbench printed its pass message
echo "$out" | grep -q "^Simulation PASSED$"
